/* zx_mem_macros.svh */
// Memory pager constants
`ifndef ZX_MEM_MACROS_SVH
`define ZX_MEM_MACROS_SVH

// ========================================
// Bus and window widths
// ========================================

`define ZX_CPU_AW 16     // CPU address bus
`define ZX_WIN_AW 14     // Offset inside one 16K window
`define ZX_RAM_AW 21     // External memory, 2M bytes
`define ZX_SPC_AW 17     // Address span of the +3 special layouts
`define ZX_BANK_W 6      // Up to 64 RAM banks
`define ZX_ROM_PAGE_W 4  // ROM page number
`define ZX_IO_DW 8       // Port write data

// ========================================
// Fixed ROM pages
// ========================================

// All ROM images sit above the RAM banks
`define ZX_ROM_PREFIX 3'b101

`define ZX_TRDOS_PAGE 4'b0101  // Disk system ROM

// Opcode fetches from 3Dxx in the 48K ROM page the disk ROM in
`define ZX_TRAP_HI 8'h3D

`endif

/* zx_mem_pkg.sv */
// Memory pager types
`default_nettype none

package zx_mem_pkg;

	// ========================================
	// Machine model
	// ========================================

	// Codes follow the memory option of the core menu
	typedef enum logic [2:0] {
		MACH_ZX128 = 3'd0, // 128K and +2
		MACH_P1024 = 3'd1, // Pentagon 1024
		MACH_ZX48  = 3'd3,
		MACH_PLUS3 = 3'd4  // +2A and +3
	} machine_t;

	// ========================================
	// Decoded port writes
	// ========================================

	typedef enum logic [1:0] {
		PORT_NONE = 2'd0,
		PORT_7FFD = 2'd1, // Main paging register
		PORT_1FFD = 2'd2, // +3 ROM select and special paging
		PORT_EFF7 = 2'd3  // Pentagon 1024 configuration
	} port_op_t;

endpackage

`default_nettype wire

/* zx_paging_regs.sv */
// Paging register block
`timescale 1ns/100ps
`default_nettype none

`include "zx_mem_macros.svh"

module zx_paging_regs import zx_mem_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire machine_t          machine_sel,
	input  wire                    psel,
	input  wire                    penable,
	input  wire                    pwrite,
	input  wire [`ZX_CPU_AW-1:0]   paddr,
	input  wire [`ZX_IO_DW-1:0]    pwdata,
	output machine_t               machine,
	output logic [`ZX_BANK_W-1:0]  ram_bank,
	output logic                   rom_sel_128,
	output logic                   rom_sel_plus3,
	output logic                   special_mode,
	output logic [1:0]             special_cfg,
	output logic                   active_48_rom
);

	logic [7:0] reg_7ffd;
	logic [2:0] reg_1ffd;      // Motor and printer bits not kept
	logic       eff7_ext_off;  // EFF7 bit 2, freezes the extended bank bits
	logic [2:0] ext_bank;      // Pentagon 1024 bank bits above 7FFD[2:0]
	port_op_t   port_op;
	logic       io_write;
	logic       locked;
	logic       is_48;
	logic       is_plus3;
	logic       is_p1024;

	assign is_48    = (machine == MACH_ZX48);
	assign is_plus3 = (machine == MACH_PLUS3);
	assign is_p1024 = (machine == MACH_P1024);

	// Access phase of an APB write
	assign io_write = psel & penable & pwrite;

	// ========================================
	// Port decoding
	// ========================================

	always_comb begin
		port_op = PORT_NONE;
		if (!paddr[15] && !paddr[1] && (paddr[14] || !is_plus3))
			port_op = PORT_7FFD;
		else if (is_plus3 && (paddr[15:12] == 4'b0001) && !paddr[1])
			port_op = PORT_1FFD;
		else if (is_p1024 && (paddr[15:13] == 3'b111) && !paddr[12] && !paddr[3])
			port_op = PORT_EFF7;
	end

	// 48K never pages, the others lock on 7FFD bit 5
	assign locked = is_48
		| (~is_p1024 & reg_7ffd[5])
		| (is_p1024 & eff7_ext_off & reg_7ffd[5]);

	// ========================================
	// Registers
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			machine      <= machine_sel; // Model only changes across a reset
			reg_7ffd     <= '0;
			reg_1ffd     <= '0;
			eff7_ext_off <= 1'b0;
			ext_bank     <= '0;
		end else if (io_write) begin
			case (port_op)
				PORT_7FFD: begin
					if (!locked) begin
						reg_7ffd <= pwdata;
						if (is_p1024 && !eff7_ext_off)
							ext_bank <= {pwdata[5], pwdata[7:6]};
					end
				end
				PORT_1FFD: begin
					if (!locked)
						reg_1ffd <= pwdata[2:0];
				end
				PORT_EFF7: eff7_ext_off <= pwdata[2]; // Not subject to the lock
				default: ;
			endcase
		end
	end

	assign ram_bank      = {ext_bank, reg_7ffd[2:0]};
	assign rom_sel_128   = reg_7ffd[4];
	assign rom_sel_plus3 = reg_1ffd[2];
	assign special_mode  = reg_1ffd[0];
	assign special_cfg   = reg_1ffd[2:1];

	// BASIC ROM visible, which arms the disk ROM trap
	assign active_48_rom = is_48
		| (reg_7ffd[4] & ~is_plus3)
		| (is_plus3 & reg_7ffd[4] & reg_1ffd[2] & ~reg_1ffd[0]);

	// While locked, 7FFD holds its value
	assert property (@(posedge clk_sys) disable iff (reset)
		locked |=> $stable(reg_7ffd))
		else $error("7FFD changed while paging was locked");

endmodule

`default_nettype wire

/* zx_rom_trap.sv */
// Disk ROM trap
`timescale 1ns/100ps
`default_nettype none

`include "zx_mem_macros.svh"

module zx_rom_trap (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire                   m1,
	input  wire [`ZX_CPU_AW-1:0]  mem_addr,
	input  wire                   active_48_rom,
	output logic                  trdos_en
);

	logic fetch_ram;  // Fetch outside window 0
	logic fetch_trap; // Fetch from the trap page of the 48K ROM

	assign fetch_ram  = m1 & (|mem_addr[15:14]);
	assign fetch_trap = m1 & (mem_addr[15:8] == `ZX_TRAP_HI) & active_48_rom;

	// ========================================
	// Enable flag
	// ========================================

	// Updated at the fetch edge, so the trapping fetch
	// itself still reads the old ROM page
	always_ff @(posedge clk_sys) begin
		if (reset)
			trdos_en <= 1'b0;
		else if (fetch_ram)
			trdos_en <= 1'b0; // Leaving ROM space pages the disk ROM out
		else if (fetch_trap)
			trdos_en <= 1'b1;
	end

	// Only opcode fetches move the flag
	assert property (@(posedge clk_sys) disable iff (reset)
		!m1 |=> $stable(trdos_en))
		else $error("Disk ROM enable changed without an opcode fetch");

endmodule

`default_nettype wire

/* zx_addr_mapper.sv */
// CPU to external address mapper
`timescale 1ns/100ps
`default_nettype none

`include "zx_mem_macros.svh"

module zx_addr_mapper import zx_mem_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire machine_t          machine,
	input  wire [`ZX_CPU_AW-1:0]   mem_addr,
	input  wire                    mem_rd,
	input  wire                    mem_wr,
	input  wire [`ZX_BANK_W-1:0]   ram_bank,
	input  wire                    rom_sel_128,
	input  wire                    rom_sel_plus3,
	input  wire                    special_mode,
	input  wire [1:0]              special_cfg,
	input  wire                    trdos_en,
	output logic [`ZX_RAM_AW-1:0]  ram_addr,
	output logic                   ram_rd,
	output logic                   ram_wr
);

	logic [1:0]                window;
	logic [`ZX_WIN_AW-1:0]     offset;
	logic [`ZX_ROM_PAGE_W-1:0] rom_page;
	logic [`ZX_RAM_AW-1:0]     addr_next;
	logic                      is_48;
	logic                      cfg_or;
	logic                      cfg_and;

	assign window  = mem_addr[15:14];
	assign offset  = mem_addr[`ZX_WIN_AW-1:0];
	assign is_48   = (machine == MACH_ZX48);
	assign cfg_or  = |special_cfg;
	assign cfg_and = &special_cfg;

	// ========================================
	// ROM page select
	// ========================================

	always_comb begin
		if (trdos_en)
			rom_page = `ZX_TRDOS_PAGE;
		else if (machine == MACH_PLUS3)
			rom_page = {2'b10, rom_sel_plus3, rom_sel_128}; // Four +3 ROMs
		else
			rom_page = {is_48, 2'b11, is_48 | rom_sel_128};
	end

	// ========================================
	// Window translation
	// ========================================

	always_comb begin
		if (special_mode) begin
			// All-RAM layouts, banks 0 to 7 only
			case (window)
				2'd0: addr_next = {{(`ZX_RAM_AW - `ZX_SPC_AW){1'b0}}, cfg_or, 2'b00, offset};
				2'd1: addr_next = {{(`ZX_RAM_AW - `ZX_SPC_AW){1'b0}}, cfg_or, cfg_and, 1'b1,
					offset};
				2'd2: addr_next = {{(`ZX_RAM_AW - `ZX_SPC_AW){1'b0}}, cfg_or, 2'b10, offset};
				default: addr_next = {{(`ZX_RAM_AW - `ZX_SPC_AW){1'b0}},
					special_cfg == 2'b01, 2'b11, offset};
			endcase
		end else begin
			case (window)
				2'd0: addr_next = {`ZX_ROM_PREFIX, rom_page, offset};
				2'd1: addr_next = {{(`ZX_RAM_AW - `ZX_BANK_W - `ZX_WIN_AW){1'b0}},
					`ZX_BANK_W'(5), offset};
				2'd2: addr_next = {{(`ZX_RAM_AW - `ZX_BANK_W - `ZX_WIN_AW){1'b0}},
					`ZX_BANK_W'(2), offset};
				default: addr_next = {{(`ZX_RAM_AW - `ZX_BANK_W - `ZX_WIN_AW){1'b0}},
					ram_bank, offset}; // Paged window at C000
			endcase
		end
	end

	// ========================================
	// Output stage
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (mem_rd || mem_wr)
			ram_addr <= addr_next; // Held between accesses
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_rd <= 1'b0;
			ram_wr <= 1'b0;
		end else begin
			ram_rd <= mem_rd;
			ram_wr <= mem_wr & (special_mode | (|window)); // ROM is read only
		end
	end

	assert property (@(posedge clk_sys) disable iff (reset) !(ram_rd && ram_wr))
		else $error("Read and write strobes raised together");

endmodule

`default_nettype wire

/* zx_memory_pager.sv */
// Memory paging unit
`timescale 1ns/100ps
`default_nettype none

`include "zx_mem_macros.svh"

module zx_memory_pager import zx_mem_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire machine_t          machine_sel,
	// APB port writes
	input  wire                    psel,
	input  wire                    penable,
	input  wire                    pwrite,
	input  wire [`ZX_CPU_AW-1:0]   paddr,
	input  wire [`ZX_IO_DW-1:0]    pwdata,
	// CPU memory cycle
	input  wire [`ZX_CPU_AW-1:0]   mem_addr,
	input  wire                    mem_rd,
	input  wire                    mem_wr,
	input  wire                    m1,
	// External memory
	output wire [`ZX_RAM_AW-1:0]   ram_addr,
	output wire                    ram_rd,
	output wire                    ram_wr
);

	wire machine_t              machine;
	wire [`ZX_BANK_W-1:0]       ram_bank;
	wire                        rom_sel_128;
	wire                        rom_sel_plus3;
	wire                        special_mode;
	wire [1:0]                  special_cfg;
	wire                        active_48_rom;
	wire                        trdos_en;

	// ========================================
	// Paging state
	// ========================================

	zx_paging_regs u_paging_regs (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.machine_sel   (machine_sel),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.machine       (machine),
		.ram_bank      (ram_bank),
		.rom_sel_128   (rom_sel_128),
		.rom_sel_plus3 (rom_sel_plus3),
		.special_mode  (special_mode),
		.special_cfg   (special_cfg),
		.active_48_rom (active_48_rom)
	);

	zx_rom_trap u_rom_trap (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.m1            (m1),
		.mem_addr      (mem_addr),
		.active_48_rom (active_48_rom),
		.trdos_en      (trdos_en)
	);

	// ========================================
	// Translation
	// ========================================

	zx_addr_mapper u_addr_mapper (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.machine       (machine),
		.mem_addr      (mem_addr),
		.mem_rd        (mem_rd),
		.mem_wr        (mem_wr),
		.ram_bank      (ram_bank),
		.rom_sel_128   (rom_sel_128),
		.rom_sel_plus3 (rom_sel_plus3),
		.special_mode  (special_mode),
		.special_cfg   (special_cfg),
		.trdos_en      (trdos_en),
		.ram_addr      (ram_addr),
		.ram_rd        (ram_rd),
		.ram_wr        (ram_wr)
	);

endmodule

`default_nettype wire

/* tb_zx_memory_pager.sv */
// Memory pager testbench
`timescale 1ns/100ps
`default_nettype none

`include "zx_mem_macros.svh"

module tb_zx_memory_pager import zx_mem_pkg::*; ();

	logic                   clk_sys;
	logic                   reset;
	machine_t               machine_sel;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [`ZX_CPU_AW-1:0]  paddr;
	logic [`ZX_IO_DW-1:0]   pwdata;
	logic [`ZX_CPU_AW-1:0]  mem_addr;
	logic                   mem_rd;
	logic                   mem_wr;
	logic                   m1;
	wire  [`ZX_RAM_AW-1:0]  ram_addr;
	wire                    ram_rd;
	wire                    ram_wr;

	integer seed = 215;
	int     errors = 0;
	int     accesses = 0;

	// Reference paging state, rebuilt from the writes below
	machine_t              ref_mach;
	logic [7:0]            ref_7ffd;
	logic [2:0]            ref_1ffd;
	logic                  ref_eff7;
	logic [2:0]            ref_ext;
	logic                  ref_trdos;
	port_op_t              ref_op;
	logic                  ref_48;
	logic                  ref_locked;
	logic                  ref_act48;
	logic [1:0]            ref_cfg;
	logic [3:0]            exp_rom;
	logic [`ZX_RAM_AW-1:0] exp_addr;
	logic [`ZX_RAM_AW-1:0] exp_addr_q;
	logic                  exp_rd_q;
	logic                  exp_wr_q;

	zx_memory_pager uut (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.machine_sel (machine_sel),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.mem_addr    (mem_addr),
		.mem_rd      (mem_rd),
		.mem_wr      (mem_wr),
		.m1          (m1),
		.ram_addr    (ram_addr),
		.ram_rd      (ram_rd),
		.ram_wr      (ram_wr)
	);

	always #10 clk_sys = ~clk_sys;

	// ========================================
	// Reference model
	// ========================================

	always_comb begin
		ref_op = PORT_NONE;
		if (!paddr[15] && !paddr[1] && (paddr[14] || ref_mach != MACH_PLUS3))
			ref_op = PORT_7FFD;
		else if (ref_mach == MACH_PLUS3 && paddr[15:12] == 4'h1 && !paddr[1])
			ref_op = PORT_1FFD;
		else if (ref_mach == MACH_P1024 && paddr[15:12] == 4'hE && !paddr[3])
			ref_op = PORT_EFF7;
	end

	assign ref_48     = (ref_mach == MACH_ZX48);
	assign ref_locked = ref_48 || (ref_7ffd[5] && (ref_mach != MACH_P1024 || ref_eff7));
	assign ref_act48  = ref_48 || (ref_7ffd[4] && ref_mach != MACH_PLUS3)
		|| (ref_mach == MACH_PLUS3 && ref_7ffd[4] && ref_1ffd[2] && !ref_1ffd[0]);
	assign ref_cfg    = ref_1ffd[2:1];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ref_mach  <= machine_sel;
			ref_7ffd  <= '0;
			ref_1ffd  <= '0;
			ref_eff7  <= 1'b0;
			ref_ext   <= '0;
			ref_trdos <= 1'b0;
		end else begin
			if (psel && penable && pwrite) begin
				if (ref_op == PORT_7FFD && !ref_locked) begin
					ref_7ffd <= pwdata;
					if (ref_mach == MACH_P1024 && !ref_eff7)
						ref_ext <= {pwdata[5], pwdata[7], pwdata[6]};
				end
				if (ref_op == PORT_1FFD && !ref_locked)
					ref_1ffd <= pwdata[2:0];
				if (ref_op == PORT_EFF7)
					ref_eff7 <= pwdata[2];
			end
			if (m1 && mem_addr[15:14] != 2'b00)
				ref_trdos <= 1'b0;
			else if (m1 && mem_addr[15:8] == `ZX_TRAP_HI && ref_act48)
				ref_trdos <= 1'b1;
		end
	end

	always_comb begin
		if (ref_trdos)
			exp_rom = `ZX_TRDOS_PAGE;
		else if (ref_mach == MACH_PLUS3)
			exp_rom = {2'b10, ref_1ffd[2], ref_7ffd[4]};
		else
			exp_rom = {ref_48, 2'b11, ref_48 | ref_7ffd[4]};
		if (ref_1ffd[0]) begin
			case (mem_addr[15:14])
				2'd0: exp_addr = {4'b0, |ref_cfg, 2'b00, mem_addr[13:0]};
				2'd1: exp_addr = {4'b0, |ref_cfg, &ref_cfg, 1'b1, mem_addr[13:0]};
				2'd2: exp_addr = {4'b0, |ref_cfg, 2'b10, mem_addr[13:0]};
				default: exp_addr = {4'b0, ref_cfg == 2'b01, 2'b11, mem_addr[13:0]};
			endcase
		end else begin
			case (mem_addr[15:14])
				2'd0: exp_addr = {`ZX_ROM_PREFIX, exp_rom, mem_addr[13:0]};
				2'd1: exp_addr = {1'b0, 6'd5, mem_addr[13:0]};
				2'd2: exp_addr = {1'b0, 6'd2, mem_addr[13:0]};
				default: exp_addr = {1'b0, ref_ext, ref_7ffd[2:0], mem_addr[13:0]};
			endcase
		end
	end

	// Expected results of the access in flight
	always_ff @(posedge clk_sys) begin
		if (mem_rd || mem_wr)
			exp_addr_q <= exp_addr;
		exp_rd_q <= mem_rd;
		exp_wr_q <= mem_wr && (ref_1ffd[0] || mem_addr[15:14] != 2'b00);
	end

	// ========================================
	// Checks
	// ========================================

	a_addr: assert property (@(posedge clk_sys) disable iff (reset)
		(mem_rd || mem_wr) |=> (ram_addr == exp_addr_q))
		else begin
			errors++;
			$display("error %0t ram_addr got %h expected %h", $time,
				$sampled(ram_addr), $sampled(exp_addr_q));
		end

	a_rd: assert property (@(posedge clk_sys) disable iff (reset)
		1'b1 |=> (ram_rd == exp_rd_q))
		else begin
			errors++;
			$display("error %0t ram_rd got %b expected %b", $time,
				$sampled(ram_rd), $sampled(exp_rd_q));
		end

	a_wr: assert property (@(posedge clk_sys) disable iff (reset)
		1'b1 |=> (ram_wr == exp_wr_q))
		else begin
			errors++;
			$display("error %0t ram_wr got %b expected %b", $time,
				$sampled(ram_wr), $sampled(exp_wr_q));
		end

	// ========================================
	// Stimulus tasks
	// ========================================

	task automatic do_reset(input machine_t m);
		@(posedge clk_sys);
		machine_sel <= m;
		reset       <= 1'b1;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	task automatic apb_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		psel    <= 1'b1; // Setup phase
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= a;
		pwdata  <= d;
		@(posedge clk_sys);
		penable <= 1'b1;
		@(posedge clk_sys);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic mem_read(input logic [15:0] a, input logic fetch);
		int wait_cycles;
		@(posedge clk_sys);
		mem_addr <= a;
		mem_rd   <= 1'b1;
		m1       <= fetch;
		@(posedge clk_sys);
		mem_rd <= 1'b0;
		m1     <= 1'b0;
		accesses++;
		wait_cycles = 0;
		do begin
			@(negedge clk_sys);
			wait_cycles++;
		end while (!ram_rd && wait_cycles < 8);
		if (!ram_rd) begin
			errors++;
			$display("Timeout: no read strobe for address %h", a);
		end
	endtask

	task automatic mem_write(input logic [15:0] a, input logic strobe);
		int wait_cycles;
		@(posedge clk_sys);
		mem_addr <= a;
		mem_wr   <= 1'b1;
		@(posedge clk_sys);
		mem_wr <= 1'b0;
		accesses++;
		wait_cycles = 0;
		do begin
			@(negedge clk_sys);
			wait_cycles++;
		end while (ram_wr != strobe && wait_cycles < 8);
		if (ram_wr != strobe) begin
			errors++;
			$display("Timeout: write strobe for address %h never reached %b", a, strobe);
		end
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		logic [13:0] off;
		logic [7:0]  data;
		clk_sys     = 1'b0;
		reset       = 1'b1;
		machine_sel = MACH_ZX128;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		mem_addr    = '0;
		mem_rd      = 1'b0;
		mem_wr      = 1'b0;
		m1          = 1'b0;

		// 128K: reset layout, bank switch, lock
		do_reset(MACH_ZX128);
		off  = $random(seed);
		data = $random(seed);
		mem_read({2'b00, off}, 1'b0);
		mem_read({2'b01, off}, 1'b0);
		apb_write(16'h7FFD, 8'h10 | (data & 8'h07));
		mem_read({2'b11, off}, 1'b0);
		mem_read({2'b00, off}, 1'b0);
		mem_write({2'b00, off}, 1'b0); // ROM stays read only
		mem_write({2'b11, off}, 1'b1);
		apb_write(16'h7FFD, 8'h20 | ((data >> 3) & 8'h07));
		apb_write(16'h7FFD, 8'h17);    // Ignored once locked
		mem_read({2'b11, off}, 1'b0);
		mem_read({2'b00, off}, 1'b0);

		// Pentagon 1024 extended banks
		do_reset(MACH_P1024);
		data = $random(seed);
		apb_write(16'h7FFD, data);
		mem_read({2'b11, off}, 1'b0);
		apb_write(16'h7FFD, data & 8'hDF);
		apb_write(16'hEFF7, 8'h04);    // Freezes the extended bits
		data = $random(seed);
		apb_write(16'h7FFD, data & 8'hDF);
		mem_read({2'b11, off}, 1'b0);
		apb_write(16'h7FFD, 8'h20);
		apb_write(16'h7FFD, 8'h07);
		mem_read({2'b11, off}, 1'b0);

		// +3 ROM select and special layouts
		do_reset(MACH_PLUS3);
		mem_read({2'b00, off}, 1'b0);
		apb_write(16'h7FFD, 8'h10);
		apb_write(16'h1FFD, 8'h04);
		mem_read({2'b00, off}, 1'b0);
		for (int cfg = 0; cfg < 4; cfg++) begin
			apb_write(16'h1FFD, {5'b00000, cfg[1:0], 1'b1});
			for (int w = 0; w < 4; w++)
				mem_read({w[1:0], off}, 1'b0);
			mem_write({2'b00, off}, 1'b1);
		end
		apb_write(16'h1FFD, 8'h04);
		mem_read({8'h3D, off[7:0]}, 1'b1);
		mem_read({2'b00, off}, 1'b0);
		mem_read(16'h8000, 1'b1);
		mem_read({2'b00, off}, 1'b0);

		// 48K disk ROM trap
		do_reset(MACH_ZX48);
		apb_write(16'h7FFD, 8'h07);
		mem_read({2'b00, off}, 1'b0);
		mem_read({`ZX_TRAP_HI, data}, 1'b1);
		mem_read({2'b00, off}, 1'b0);
		mem_read({2'b11, off}, 1'b0);
		mem_read(16'h8000, 1'b1);
		mem_read({2'b00, off}, 1'b0);

		repeat (2) @(posedge clk_sys);
		$display("Checks done, %0d accesses, %0d errors", accesses, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Watchdog over the whole run
	initial begin
		#100000;
		$display("Timeout: test sequence did not complete");
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* zx_memory_pager.f */
+incdir+.
zx_mem_pkg.sv
zx_paging_regs.sv
zx_rom_trap.sv
zx_addr_mapper.sv
zx_memory_pager.sv
tb_zx_memory_pager.sv

/* Bender.yml */
package:
  name: zx_memory_pager

sources:
  - include_dirs:
      - .
    files:
      - zx_mem_pkg.sv
      - zx_paging_regs.sv
      - zx_rom_trap.sv
      - zx_addr_mapper.sv
      - zx_memory_pager.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_zx_memory_pager.sv
